//--- verilog.f
verilog/laluPkg.sv
verilog/decodedIf.sv
verilog/fetchUnit.sv
verilog/decodeStage.sv
verilog/regFile.sv
verilog/executeUnit.sv
verilog/laluCore.sv
verif/laluTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module laluTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/VlaluTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Everything OK$"; then
    exit 0
fi
exit 1

//--- verif/laluTb.sv
// self-checking run with a 256-word program memory; registers and flags carry over between tests
`timescale 1ns/1ps
`default_nettype none

module laluTb import laluPkg::*; ();

    localparam int numTests = 6;
    localparam int maxProgLen = 256;

    logic          CLOCK_50 = 1'b0;
    logic          arstN;
    logic          run;
    logic          progWrite;
    logic [7:0]    progAddr;
    word_t         progData;
    wire           regWriteValid;
    wire regAddr_t regWriteAddr;
    wire word_t    regWriteData;
    wire           generalFlag;

    word_t    prog [0:maxProgLen-1];
    int       progLen;
    word_t    mReg [0:31];          // model register file
    logic     mN, mZ, mC, mV, mGf;  // model flags
    word_t    expData [$];
    regAddr_t expAddr [$];
    int       expIdx;
    int       errors;
    int       tests;
    int       seed = 50242;
    logic     checking;

    laluCore #(.imemAddrWidth(8)) u_laluCore (
        .CLOCK_50(CLOCK_50), .arstN(arstN), .run(run), .progWrite(progWrite),
        .progAddr(progAddr), .progData(progData), .regWriteValid(regWriteValid),
        .regWriteAddr(regWriteAddr), .regWriteData(regWriteData), .generalFlag(generalFlag)
    );

    always #10 CLOCK_50 = ~CLOCK_50;

    function automatic word_t trip(input logic c, input logic n, input logic s, input format_t f,
                                   input funcId_t fn, input regAddr_t rd, input regAddr_t rs0,
                                   input regAddr_t rs1, input logic i0, input logic i1);
        return {c, n, s, rd, rs0, rs1, fn, i0, i1, f};
    endfunction

    function automatic word_t jmpTo(input int t);
        return {6'b0, 21'(t), FN_JUMP, FMT_JMP};
    endfunction

    task automatic emit(input word_t w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic wb(input funcId_t fn, input regAddr_t rd, input regAddr_t rs0,
                      input regAddr_t rs1, input logic i0, input logic i1);
        emit(trip(1'b0, 1'b0, 1'b0, FMT_WB_TRIP, fn, rd, rs0, rs1, i0, i1));
    endtask

    // builds a 32-bit constant from the top two bits and then six 5-bit groups
    task automatic loadConst(input regAddr_t rd, input word_t v);
        wb(FN_ADD, rd, regAddr_t'(v[31:30]), 5'd0, 1'b1, 1'b1);
        for (int k = 5; k >= 0; k--) begin
            wb(FN_BSL, rd, rd, 5'd5, 1'b0, 1'b1);
            wb(FN_ADD, rd, rd, v[k*5 +: 5], 1'b0, 1'b1);
        end
    endtask

    // flag-get followed by a conditional write that shows the flag
    task automatic flagProbe();
        for (int k = 0; k < 8; k++) begin
            emit(trip(1'b0, 1'b0, 1'b0, FMT_NO_WB_TRIP, funcId_t'(9'h090 + k), 0, 0, 0, 0, 0));
            emit(trip(1'b1, 1'b0, 1'b0, FMT_WB_TRIP, FN_ADD, 5'd5, 5'(k), 5'd0, 1'b1, 1'b1));
        end
    endtask

    task automatic aluModel(input funcId_t fn, input word_t a, input word_t b, output word_t r,
                            output logic c, output logic v, output logic known);
        logic [32:0] s;
        int          sh;
        sh = b % 32;
        r = '0;
        c = 1'b0;
        v = 1'b0;
        known = 1'b1;
        case (fn)
            FN_ADD: begin
                {c, r} = {1'b0, a} + {1'b0, b};
                s = {a[31], a} + {b[31], b};
                v = s[32] != s[31];
            end
            FN_SUB: begin
                r = a - b;
                c = a < b;
                s = {a[31], a} - {b[31], b};
                v = s[32] != s[31];
            end
            FN_MUL: r = 32'(a[15:0]) * 32'(b[15:0]);
            FN_BSL: begin
                r = a << sh;
                c = (sh == 0) ? 1'b0 : a[32-sh];
            end
            FN_BSR: begin
                r = a >> sh;
                c = (sh == 0) ? 1'b0 : a[sh-1];
            end
            FN_BRL: r = (sh == 0) ? a : ((a << sh) | (a >> (32 - sh)));
            FN_BRR: r = (sh == 0) ? a : ((a >> sh) | (a << (32 - sh)));
            FN_ANY: r = (a != 0) ? 32'd1 : 32'd0;
            FN_HSB: begin
                for (int i = 31; i >= 0 && r == 0; i--) begin
                    if (a[i]) r[i] = 1'b1;
                end
            end
            default: known = 1'b0;
        endcase
    endtask

    // executes prog in order until an unskipped jump to itself and returns its address
    task automatic runModel(output int endPc);
        int    pc;
        int    steps;
        word_t w, a, b, r;
        logic  skip, c, v, known, gf;
        pc = 0;
        steps = 0;
        endPc = -1;
        while (endPc < 0 && steps < 2000) begin
            w = prog[pc];
            a = w[4] ? word_t'(w[23:19]) : mReg[w[23:19]];
            b = w[3] ? word_t'(w[18:14]) : mReg[w[18:14]];
            skip = w[31] && (mGf == w[30]);
            steps++;
            pc++;
            if (!skip && w[2:0] == FMT_JMP && w[4:3] == FN_JUMP) begin
                if (int'(w[12:5]) == pc - 1) endPc = pc - 1;
                pc = int'(w[12:5]);
            end else if (!skip && w[2:0] == FMT_WB_TRIP) begin
                aluModel(w[13:5], a, b, r, c, v, known);
                if (known) begin
                    mReg[w[28:24]] = r;
                    expAddr.push_back(w[28:24]);
                    expData.push_back(r);
                    if (w[29]) {mN, mZ, mC, mV} = {r[31], r == 0, c, v};
                end
            end else if (!skip && w[2:0] == FMT_NO_WB_TRIP) begin
                known = 1'b1;
                case (w[13:5])
                    FN_UGT: gf = a > b;
                    FN_UGE: gf = a >= b;
                    FN_ULT: gf = a < b;
                    FN_ULE: gf = a <= b;
                    FN_SGT: gf = $signed(a) > $signed(b);
                    FN_SGE: gf = $signed(a) >= $signed(b);
                    FN_SLT: gf = $signed(a) < $signed(b);
                    FN_SLE: gf = $signed(a) <= $signed(b);
                    FN_EQ:  gf = a == b;
                    FN_NE:  gf = a != b;
                    FN_NF:  gf = mN;
                    FN_ZF:  gf = mZ;
                    FN_CF:  gf = mC;
                    FN_OF:  gf = mV;
                    FN_NNF: gf = !mN;
                    FN_NZF: gf = !mZ;
                    FN_NCF: gf = !mC;
                    FN_NOF: gf = !mV;
                    default: known = 1'b0;
                endcase
                if (known) mGf = gf;
            end
        end
    endtask

    task automatic runTest(input string name);
        int endPc;
        int errBefore;
        errBefore = errors;
        emit(jmpTo(progLen));   // final self-jump
        for (int i = 0; i < progLen; i++) begin
            @(negedge CLOCK_50);
            progWrite = 1'b1;
            progAddr  = 8'(i);
            progData  = prog[i];
        end
        @(negedge CLOCK_50);
        progWrite = 1'b0;
        runModel(endPc);
        expIdx = 0;
        checking = 1'b1;
        run = 1'b1;
        do @(negedge CLOCK_50);
        while (!(u_laluCore.redirect && u_laluCore.redirectTarget[7:0] == 8'(endPc)));
        repeat (3) @(negedge CLOCK_50);
        run = 1'b0;
        @(negedge CLOCK_50);
        checking = 1'b0;
        assert (expIdx == expAddr.size()) else begin
            $display("%s: only %0d of %0d expected writes seen", name, expIdx, expAddr.size());
            errors++;
        end
        assert (generalFlag == mGf) else begin
            $display("[FAIL] %0t generalFlag exp %0b got %0b", $time, mGf, generalFlag);
            errors++;
        end
        $display("test %s: %0d writes, %0d errors", name, expIdx, errors - errBefore);
        tests++;
        expAddr.delete();
        expData.delete();
        progLen = 0;
    endtask

    always @(negedge CLOCK_50) begin
        if (checking && regWriteValid) begin
            assert (expIdx < expAddr.size()) else begin
                $display("register write to r%0d beyond the expected list at %0t",
                         regWriteAddr, $time);
                errors++;
            end
            if (expIdx < expAddr.size()) begin
                assert (regWriteAddr == expAddr[expIdx]) else begin
                    $display("[FAIL] %0t regWriteAddr exp %0d got %0d", $time,
                             expAddr[expIdx], regWriteAddr);
                    errors++;
                end
                assert (regWriteData == expData[expIdx]) else begin
                    $display("[FAIL] %0t regWriteData exp %h got %h", $time,
                             expData[expIdx], regWriteData);
                    errors++;
                end
                expIdx++;
            end
        end
    end

    initial begin
        #(numTests * maxProgLen * 8 * 20);
        $display("watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

    initial begin
        word_t pa [0:3];
        word_t pb [0:3];
        {arstN, run, progWrite, progAddr, progData, checking} = '0;
        {mN, mZ, mC, mV, mGf} = '0;
        errors = 0;
        tests = 0;
        progLen = 0;
        for (int i = 0; i < 32; i++) mReg[i] = '0;
        repeat (10) @(negedge CLOCK_50);
        arstN = 1'b1;

        loadConst(5'd1, $random(seed));
        loadConst(5'd2, $random(seed));
        for (int i = 0; i < 40; i++) begin
            emit(trip(1'b0, 1'b0, 1'($random(seed)), FMT_WB_TRIP,
                      funcId_t'(1 + i % 9), 5'(1 + {$random(seed)} % 7),
                      5'(1 + {$random(seed)} % 7), 5'($random(seed)),
                      1'($random(seed)), 1'($random(seed))));
        end
        flagProbe();
        runTest("alu");

        pa[0] = $random(seed);
        pb[0] = $random(seed);
        pa[1] = pa[0];
        pb[1] = pa[0];
        pa[2] = 32'h8000_0000;
        pb[2] = 32'h0000_0001;
        pa[3] = 32'h0000_0000;
        pb[3] = 32'hFFFF_FFFF;
        for (int p = 0; p < 4; p++) begin
            loadConst(5'd1, pa[p]);
            loadConst(5'd2, pb[p]);
            for (int k = 0; k < 10; k++) begin
                emit(trip(1'b0, 1'b0, 1'b0, FMT_NO_WB_TRIP, funcId_t'(9'h080 + k), 0, 1, 2, 0, 0));
                emit(trip(1'b1, 1'b0, 1'b0, FMT_WB_TRIP, FN_ADD, 5'd3, 5'd0, 5'(k), 1'b1, 1'b1));
            end
        end
        runTest("compare");

        loadConst(5'd1, 32'h7FFF_FFFF);
        loadConst(5'd2, 32'hFFFF_FFFF);
        emit(trip(1'b0, 1'b0, 1'b1, FMT_WB_TRIP, FN_ADD, 5'd3, 5'd1, 5'd1, 1'b0, 1'b1));
        wb(FN_ADD, 5'd4, 5'd2, 5'd1, 1'b0, 1'b1);
        flagProbe();
        emit(trip(1'b0, 1'b0, 1'b1, FMT_WB_TRIP, FN_ADD, 5'd3, 5'd2, 5'd1, 1'b0, 1'b1));
        wb(FN_SUB, 5'd4, 5'd0, 5'd1, 1'b1, 1'b1);
        flagProbe();
        emit(trip(1'b0, 1'b0, 1'b1, FMT_WB_TRIP, FN_SUB, 5'd3, 5'd0, 5'd1, 1'b1, 1'b1));
        flagProbe();
        runTest("sticky");

        for (int f = 0; f < 2; f++) begin
            emit(trip(1'b0, 1'b0, 1'b0, FMT_NO_WB_TRIP, f ? FN_NE : FN_EQ, 0, 0, 0, 1, 1));
            for (int n = 0; n < 2; n++) begin
                emit(trip(1'b1, 1'(n), 1'b0, FMT_WB_TRIP, FN_ADD, 5'd6, 5'(2 * f + n), 5'd1,
                          1'b1, 1'b1));
            end
        end
        runTest("conditional");

        wb(FN_ADD, 5'd8, 5'd1, 5'd0, 1'b1, 1'b1);
        emit(jmpTo(7));
        for (int k = 2; k < 7; k++) wb(FN_ADD, 5'd9, 5'(k), 5'd0, 1'b1, 1'b1);
        wb(FN_ADD, 5'd10, 5'd7, 5'd0, 1'b1, 1'b1);
        wb(FN_ADD, 5'd11, 5'd8, 5'd0, 1'b1, 1'b1);
        runTest("jump");

        emit(trip(1'b0, 1'b0, 1'b0, FMT_NO_WB_TRIP, FN_EQ, 0, 0, 0, 1, 1));
        emit(trip(1'b0, 1'b0, 1'b0, FMT_WB_TRIP, 9'h1FF, 5'd7, 5'd1, 5'd1, 1'b1, 1'b1));
        emit(trip(1'b0, 1'b0, 1'b0, FMT_NO_WB_TRIP, 9'h0AA, 5'd7, 5'd1, 5'd2, 1'b1, 1'b1));
        emit(trip(1'b0, 1'b0, 1'b0, 3'b001, FN_EQ, 5'd7, 5'd1, 5'd2, 1'b1, 1'b1));
        emit({6'b0, 21'd0, 2'b10, FMT_JMP});   // jump format with an unknown function
        emit(trip(1'b1, 1'b0, 1'b0, FMT_WB_TRIP, FN_ADD, 5'd12, 5'd9, 5'd0, 1'b1, 1'b1));
        runTest("invalid");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/laluCore.sv
// load the program with run low; regWrite outputs trail each execute cycle by one clock
`timescale 1ns/1ps
`default_nettype none

module laluCore import laluPkg::*; #(
    parameter int imemAddrWidth = 8
) (
    input  wire                     CLOCK_50,
    input  wire                     arstN,
    input  wire                     run,
    input  wire                     progWrite,
    input  wire [imemAddrWidth-1:0] progAddr,
    input  wire word_t              progData,
    output logic                    regWriteValid,
    output regAddr_t                regWriteAddr,
    output word_t                   regWriteData,
    output logic                    generalFlag
);

    logic       fetchValid;
    word_t      fetchWord;
    logic       redirect;
    jumpField_t redirectTarget;

    decodedIf dec ();

    fetchUnit #(
        .imemAddrWidth (imemAddrWidth)
    ) u_fetchUnit (
        .CLOCK_50       (CLOCK_50),
        .arstN          (arstN),
        .run            (run),
        .progWrite      (progWrite),
        .progAddr       (progAddr),
        .progData       (progData),
        .redirect       (redirect),
        .redirectTarget (redirectTarget),
        .fetchValid     (fetchValid),
        .fetchWord      (fetchWord)
    );

    decodeStage u_decodeStage (
        .CLOCK_50   (CLOCK_50),
        .arstN      (arstN),
        .fetchValid (fetchValid),
        .fetchWord  (fetchWord),
        .redirect   (redirect),
        .dec        (dec.stage)
    );

    executeUnit u_executeUnit (
        .CLOCK_50       (CLOCK_50),
        .arstN          (arstN),
        .dec            (dec.exec),
        .redirect       (redirect),
        .redirectTarget (redirectTarget),
        .regWriteValid  (regWriteValid),
        .regWriteAddr   (regWriteAddr),
        .regWriteData   (regWriteData),
        .generalFlag    (generalFlag)
    );

endmodule

`default_nettype wire

//--- verilog/executeUnit.sv
// single-cycle execute; unknown function IDs do nothing, compares are true unsigned/signed tests
`timescale 1ns/1ps
`default_nettype none

module executeUnit import laluPkg::*; (
    input  wire         CLOCK_50,
    input  wire         arstN,
    decodedIf.exec      dec,
    output logic        redirect,
    output jumpField_t  redirectTarget,
    output logic        regWriteValid,
    output regAddr_t    regWriteAddr,
    output word_t       regWriteData,
    output logic        generalFlag
);

    word_t       readDataA;
    word_t       readDataB;
    word_t       opA;
    word_t       opB;
    logic [4:0]  shAmt;
    logic [32:0] sum;
    logic [32:0] diff;
    logic [32:0] bslWide;
    logic [32:0] bsrWide;
    logic [63:0] rolWide;
    logic [63:0] rorWide;
    word_t       result;
    logic        aluCarry;
    logic        aluOverflow;
    logic        wbKnown;
    logic        gfNext;
    logic        gfKnown;
    logic        negFlag;
    logic        zeroFlag;
    logic        carryFlag;
    logic        ovfFlag;
    logic        execOk;
    logic        doWrite;
    logic        doFlag;

    function automatic word_t highestSetBit(input word_t v);
        word_t h;
        h = '0;
        for (int i = 0; i < WORD_W; i++) begin
            if (v[i]) begin
                h = word_t'(1) << i;   // later (higher) bits win
            end
        end
        return h;
    endfunction

    regFile u_regFile (
        .CLOCK_50    (CLOCK_50),
        .arstN       (arstN),
        .readAddrA   (dec.rs0),
        .readAddrB   (dec.rs1),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .writeEnable (doWrite),
        .writeAddr   (dec.rd),
        .writeData   (result)
    );

    assign opA     = dec.imm0 ? word_t'(dec.rs0) : readDataA;  // immediate is the field itself
    assign opB     = dec.imm1 ? word_t'(dec.rs1) : readDataB;
    assign shAmt   = opB[4:0];
    assign sum     = {1'b0, opA} + {1'b0, opB};
    assign diff    = {1'b0, opA} - {1'b0, opB};               // bit 32 is the borrow
    assign bslWide = {1'b0, opA} << shAmt;                     // bit 32 is last bit out
    assign bsrWide = {opA, 1'b0} >> shAmt;                     // bit 0 is last bit out
    assign rolWide = {opA, opA} << shAmt;
    assign rorWide = {opA, opA} >> shAmt;

    // writeback functions
    always_comb begin
        result      = '0;
        aluCarry    = 1'b0;
        aluOverflow = 1'b0;
        wbKnown     = 1'b1;
        case (dec.funcId)
            FN_ADD: begin
                result      = sum[31:0];
                aluCarry    = sum[32];
                aluOverflow = (opA[31] == opB[31]) && (sum[31] != opA[31]);
            end
            FN_SUB: begin
                result      = diff[31:0];
                aluCarry    = diff[32];
                aluOverflow = (opA[31] != opB[31]) && (diff[31] != opA[31]);
            end
            FN_MUL: result = opA[15:0] * opB[15:0];
            FN_BSL: begin
                result   = bslWide[31:0];
                aluCarry = bslWide[32];
            end
            FN_BSR: begin
                result   = bsrWide[32:1];
                aluCarry = bsrWide[0];
            end
            FN_BRL: result = rolWide[63:32];
            FN_BRR: result = rorWide[31:0];
            FN_ANY: result = word_t'(opA != '0);
            FN_HSB: result = highestSetBit(opA);
            default: wbKnown = 1'b0;
        endcase
    end

    // compares and flag gets
    always_comb begin
        gfNext  = 1'b0;
        gfKnown = 1'b1;
        case (dec.funcId)
            FN_UGT: gfNext = opA > opB;
            FN_UGE: gfNext = opA >= opB;
            FN_ULT: gfNext = opA < opB;
            FN_ULE: gfNext = opA <= opB;
            FN_SGT: gfNext = $signed(opA) > $signed(opB);
            FN_SGE: gfNext = $signed(opA) >= $signed(opB);
            FN_SLT: gfNext = $signed(opA) < $signed(opB);
            FN_SLE: gfNext = $signed(opA) <= $signed(opB);
            FN_EQ:  gfNext = opA == opB;
            FN_NE:  gfNext = opA != opB;
            FN_NF:  gfNext = negFlag;
            FN_ZF:  gfNext = zeroFlag;
            FN_CF:  gfNext = carryFlag;
            FN_OF:  gfNext = ovfFlag;
            FN_NNF: gfNext = !negFlag;
            FN_NZF: gfNext = !zeroFlag;
            FN_NCF: gfNext = !carryFlag;
            FN_NOF: gfNext = !ovfFlag;
            default: gfKnown = 1'b0;
        endcase
    end

    // skipped when conditional and the flag matches negate
    assign execOk         = dec.valid && !(dec.conditional && (generalFlag == dec.negate));
    assign doWrite        = execOk && (dec.format == FMT_WB_TRIP) && wbKnown;
    assign doFlag         = execOk && (dec.format == FMT_NO_WB_TRIP) && gfKnown;
    assign redirect       = execOk && (dec.format == FMT_JMP) && (dec.funcId == funcId_t'(FN_JUMP));
    assign redirectTarget = dec.jumpTarget;

    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            regWriteValid <= 1'b0;
            generalFlag   <= 1'b0;
            negFlag       <= 1'b0;
            zeroFlag      <= 1'b0;
            carryFlag     <= 1'b0;
            ovfFlag       <= 1'b0;
        end else begin
            regWriteValid <= doWrite;
            if (doWrite && dec.sticky) begin
                negFlag   <= result[31];
                zeroFlag  <= result == '0;
                carryFlag <= aluCarry;
                ovfFlag   <= aluOverflow;
            end
            if (doFlag) begin
                generalFlag <= gfNext;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (doWrite) begin
            regWriteAddr <= dec.rd;
            regWriteData <= result;
        end
    end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
// reads are combinational and see a write only after the clock edge, no internal bypass
`timescale 1ns/1ps
`default_nettype none

module regFile import laluPkg::*; (
    input  wire           CLOCK_50,
    input  wire           arstN,
    input  wire regAddr_t readAddrA,
    input  wire regAddr_t readAddrB,
    output word_t         readDataA,
    output word_t         readDataB,
    input  wire           writeEnable,
    input  wire regAddr_t writeAddr,
    input  wire word_t    writeData
);

    localparam int numRegs = 2 ** REG_ADDR_W;

    word_t regs [0:numRegs-1];

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

`default_nettype wire

//--- verilog/decodeStage.sv
// unknown formats pass through with all operand fields cleared so execute ignores them
`timescale 1ns/1ps
`default_nettype none

module decodeStage import laluPkg::*; (
    input  wire        CLOCK_50,
    input  wire        arstN,
    input  wire        fetchValid,
    input  wire word_t fetchWord,
    input  wire        redirect,
    decodedIf.stage    dec
);

    format_t wordFormat;

    assign wordFormat = fetchWord[FMT_LSB +: FORMAT_W];

    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= fetchValid && !redirect;  // squash on a taken jump
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (fetchValid) begin
            dec.format      <= wordFormat;
            dec.conditional <= fetchWord[COND_BIT];
            dec.negate      <= fetchWord[NEG_BIT];
            dec.sticky      <= fetchWord[STICKY_BIT];
            case (wordFormat)
                FMT_WB_TRIP, FMT_NO_WB_TRIP: begin
                    dec.rd         <= fetchWord[RD_LSB +: REG_ADDR_W];
                    dec.rs0        <= fetchWord[RS0_LSB +: REG_ADDR_W];
                    dec.rs1        <= fetchWord[RS1_LSB +: REG_ADDR_W];
                    dec.funcId     <= fetchWord[FUNC_LSB +: FUNC_ID_W];
                    dec.imm0       <= fetchWord[IMM0_BIT];
                    dec.imm1       <= fetchWord[IMM1_BIT];
                    dec.jumpTarget <= '0;
                end
                FMT_JMP: begin
                    dec.rd         <= '0;                // jumps never name registers
                    dec.rs0        <= '0;
                    dec.rs1        <= '0;
                    dec.funcId     <= funcId_t'(fetchWord[JMP_FN_LSB +: JMP_FN_W]);
                    dec.imm0       <= 1'b0;
                    dec.imm1       <= 1'b0;
                    dec.jumpTarget <= fetchWord[JMP_TGT_LSB +: JMP_FIELD_W];
                end
                default: begin
                    dec.rd         <= '0;
                    dec.rs0        <= '0;
                    dec.rs1        <= '0;
                    dec.funcId     <= '0;
                    dec.imm0       <= 1'b0;
                    dec.imm1       <= 1'b0;
                    dec.jumpTarget <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetchUnit.sv
// program memory is written only while run is low; jump targets above the depth wrap silently
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import laluPkg::*; #(
    parameter int imemAddrWidth = 8
) (
    input  wire                     CLOCK_50,
    input  wire                     arstN,
    input  wire                     run,
    input  wire                     progWrite,
    input  wire [imemAddrWidth-1:0] progAddr,
    input  wire word_t              progData,
    input  wire                     redirect,
    input  wire jumpField_t         redirectTarget,
    output logic                    fetchValid,
    output word_t                   fetchWord
);

    localparam int imemDepth = 2 ** imemAddrWidth;

    word_t                    imem [0:imemDepth-1];
    logic [imemAddrWidth-1:0] ip;                     // instruction pointer

    // synchronous program memory, the word shows up one cycle after ip
    always_ff @(posedge CLOCK_50) begin
        if (progWrite && !run) begin
            imem[progAddr] <= progData;
        end
        fetchWord <= imem[ip];
    end

    always_ff @(posedge CLOCK_50 or negedge arstN) begin
        if (!arstN) begin
            ip         <= '0;
            fetchValid <= 1'b0;
        end else if (!run) begin
            ip         <= '0;                          // halted, restart from word 0
            fetchValid <= 1'b0;
        end else if (redirect) begin
            // word now in flight belongs to the old path
            ip         <= redirectTarget[imemAddrWidth-1:0];
            fetchValid <= 1'b0;
        end else begin
            ip         <= ip + 1'b1;
            fetchValid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/decodedIf.sv
// one decoded instruction per cycle, no back-pressure; jumpTarget is the full 21-bit field
`timescale 1ns/1ps
`default_nettype none

interface decodedIf import laluPkg::*; ();

    logic       valid;
    format_t    format;
    funcId_t    funcId;       // jump function is zero-extended here
    regAddr_t   rd;
    regAddr_t   rs0;
    regAddr_t   rs1;
    logic       imm0;
    logic       imm1;
    logic       conditional;
    logic       negate;
    logic       sticky;
    jumpField_t jumpTarget;

    modport stage (
        output valid, format, funcId, rd, rs0, rs1, imm0, imm1,
        output conditional, negate, sticky, jumpTarget
    );

    modport exec (
        input valid, format, funcId, rd, rs0, rs1, imm0, imm1,
        input conditional, negate, sticky, jumpTarget
    );

endinterface

`default_nettype wire

//--- verilog/laluPkg.sv
// covers the triple and jump encodings only; quad formats, memory ops and calls are not defined
`default_nettype none

package laluPkg;

    localparam int WORD_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int FUNC_ID_W   = 9;
    localparam int FORMAT_W    = 3;
    localparam int JMP_FIELD_W = 21;
    localparam int JMP_FN_W    = 2;

    typedef logic [WORD_W-1:0]      word_t;       // register values, results, instructions
    typedef logic [REG_ADDR_W-1:0]  regAddr_t;    // register number, also the 5-bit immediate
    typedef logic [FUNC_ID_W-1:0]   funcId_t;
    typedef logic [FORMAT_W-1:0]    format_t;
    typedef logic [JMP_FIELD_W-1:0] jumpField_t;  // raw jump target field
    typedef logic [JMP_FN_W-1:0]    jumpFn_t;

    // instruction field positions
    localparam int COND_BIT    = 31;
    localparam int NEG_BIT     = 30;
    localparam int STICKY_BIT  = 29;
    localparam int RD_LSB      = 24;
    localparam int RS0_LSB     = 19;
    localparam int RS1_LSB     = 14;
    localparam int FUNC_LSB    = 5;
    localparam int IMM0_BIT    = 4;
    localparam int IMM1_BIT    = 3;
    localparam int FMT_LSB     = 0;
    localparam int JMP_TGT_LSB = 5;   // jump target sits in bits 25..5
    localparam int JMP_FN_LSB  = 3;

    localparam format_t FMT_WB_TRIP    = 3'b000;
    localparam format_t FMT_NO_WB_TRIP = 3'b100;
    localparam format_t FMT_JMP        = 3'b110;

    // writeback functions
    localparam funcId_t FN_ADD = 9'h001;
    localparam funcId_t FN_SUB = 9'h002;
    localparam funcId_t FN_MUL = 9'h003;
    localparam funcId_t FN_BSL = 9'h004;
    localparam funcId_t FN_BSR = 9'h005;
    localparam funcId_t FN_BRL = 9'h006;
    localparam funcId_t FN_BRR = 9'h007;
    localparam funcId_t FN_ANY = 9'h008;
    localparam funcId_t FN_HSB = 9'h009;

    // compares, result goes to the general flag
    localparam funcId_t FN_UGT = 9'h080;
    localparam funcId_t FN_UGE = 9'h081;
    localparam funcId_t FN_ULT = 9'h082;
    localparam funcId_t FN_ULE = 9'h083;
    localparam funcId_t FN_SGT = 9'h084;
    localparam funcId_t FN_SGE = 9'h085;
    localparam funcId_t FN_SLT = 9'h086;
    localparam funcId_t FN_SLE = 9'h087;
    localparam funcId_t FN_EQ  = 9'h088;
    localparam funcId_t FN_NE  = 9'h089;

    // flag gets and their negations
    localparam funcId_t FN_NF  = 9'h090;
    localparam funcId_t FN_ZF  = 9'h091;
    localparam funcId_t FN_CF  = 9'h092;
    localparam funcId_t FN_OF  = 9'h093;
    localparam funcId_t FN_NNF = 9'h094;
    localparam funcId_t FN_NZF = 9'h095;
    localparam funcId_t FN_NCF = 9'h096;
    localparam funcId_t FN_NOF = 9'h097;

    localparam jumpFn_t FN_JUMP = 2'b01;

endpackage

`default_nettype wire
